// File: tb/mem_trace.txt
# op addr data be exp, hex; W write, R read, F fill start, I idle addr cycles
# D wait done, C read all words expecting data, X addr random pairs, T test id
T 1 0 0 0
R 0 0 0 00000000
R 3f 0 0 00000000
T 2 0 0 0
W 1 deadbeef f 0
R 1 0 0 deadbeef
I 3 0 0 0
W 4 0badf00d f 0
R 4 0 0 0badf00d
R 1 0 0 deadbeef
T 3 0 0 0
W 3 11223344 f 0
W 3 aabbccdd 5 0
R 3 0 0 11bb33dd
W 3 55667788 a 0
R 3 0 0 55bb77dd
T 4 0 0 0
F 0 a5a5f00d 0 0
D 0 0 0 0
C 0 a5a5f00d 0 0
T 5 0 0 0
F 0 12345678 0 0
I a 0 0 0
W 2 cafef00d f 0
W 5 00ff00ff 3 0
F 0 87654321 0 0
D 0 0 0 0
R 2 0 0 cafef00d
R 5 0 0 123400ff
R 28 0 0 12345678
T 6 0 0 0
X 40 0 0 0

// File: sim.f
hdl/memPkg.sv
hdl/sramDualPort.sv
hdl/wordCounter.sv
hdl/fillCtrl.sv
hdl/memSubsys.sv
tb/memScoreboard.sv
tb/memSubsys_chk.sv
tb/memSubsys_tb.sv

// File: Makefile
SHELL    := /bin/bash
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = memSubsys_tb
FILELIST  = sim.f
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	set -o pipefail; ./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: tb/memSubsys_tb.sv
// Memory subsystem testbench
// Reads the command trace, drives the host and fill inputs on the
// falling edge, and leaves all comparing to the scoreboard

`timescale 1ns/1ps

module memSubsys_tb;
  import memPkg::*;

  localparam int unsigned NumWords = 64;
  localparam int unsigned Latency  = 2;

  logic  clk_i = 1'b0;
  logic  rstN_i;
  logic  hostReq_i, hostWe_i, fillStart_i, fillBusy_o, fillDone_o, expValid;
  addr_t hostAddr_i;
  data_t hostWdata_i, hostRdata_o, fillPattern_i, expData;
  be_t   hostBe_i;
  int    testId = 0;
  int    checks, errors;
  int    limit = 0; // Watchdog cycles
  logic [7:0] opC [$]; // Trace columns
  int         opA [$];
  data_t      opD [$];
  be_t        opB [$];
  data_t      opE [$];

  always #50 clk_i = ~clk_i;

  memSubsys #(.NumWords(NumWords), .Latency(Latency)) i_memSubsys (.*);

  memScoreboard #(.NumWords(NumWords), .Latency(Latency)) i_scoreboard (
    .hostRdata_i (hostRdata_o), .fillBusy_i (fillBusy_o), .fillDone_i (fillDone_o),
    .expValid_i (expValid), .expData_i (expData), .testId_i (testId),
    .checks_o (checks), .errors_o (errors), .*);

  task automatic clearInputs();
    hostReq_i = 1'b0;
    hostWe_i  = 1'b0;
    fillStart_i = 1'b0;
    expValid  = 1'b0;
  endtask

  task automatic nextCycle(); // Step to the falling edge, bus idle
    @(negedge clk_i);
    clearInputs();
  endtask

  task automatic hostAccess(input logic we, input int a, input data_t d, input be_t b,
                            input logic ev, input data_t e);
    nextCycle();
    hostReq_i = 1'b1;
    hostWe_i = we;
    hostAddr_i = addr_t'(a);
    hostWdata_i = d;
    hostBe_i = b;
    expValid = ev;
    expData = e;
  endtask

  task automatic loadTrace(output bit ok);
    int fd, n, a, cyc;
    logic [7:0] c;
    data_t d, e;
    be_t b;
    string line;
    fd = $fopen("tb/mem_trace.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      cyc = 0;
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n = 0;
        if (line.len() > 0 && line[0] != "#") n = $sscanf(line, "%c %h %h %h %h", c, a, d, b, e);
        if (n == 5) begin
          opC.push_back(c);
          opA.push_back(a);
          opD.push_back(d);
          opB.push_back(b);
          opE.push_back(e);
          case (c) // Estimated cycles per command
            "I": cyc += a;
            "X": cyc += 2 * a;
            "C": cyc += NumWords + Latency;
            "T": cyc += 3;
            default: cyc += 1;
          endcase
        end
      end
      $fclose(fd);
      limit = cyc + 4 * NumWords;
    end
  endtask

  task automatic runTrace();
    for (int i = 0; i < opC.size(); i++) begin
      case (opC[i])
        "W": hostAccess(1'b1, opA[i], opD[i], opB[i], 1'b0, '0);
        "R": hostAccess(1'b0, opA[i], '0, '0, 1'b1, opE[i]);
        "F": begin
          nextCycle();
          fillStart_i = 1'b1;
          fillPattern_i = opD[i];
        end
        "I": repeat (opA[i]) nextCycle();
        "D": do nextCycle(); while (!fillDone_o); // Watchdog guards this
        "C": for (int w = 0; w < NumWords; w++) hostAccess(1'b0, w, '0, '0, 1'b1, opD[i]);
        "X": repeat (opA[i]) begin
          int ra;
          ra = int'($urandom % NumWords);
          hostAccess(1'b1, ra, data_t'($urandom), be_t'($urandom), 1'b0, '0);
          hostAccess(1'b0, ra, '0, '0, 1'b0, '0); // Model gives the expectation
        end
        "T": begin
          repeat (3) nextCycle(); // Let pending reads drain
          testId = opA[i];
        end
        default: $display("Unknown trace command %c skipped", opC[i]);
      endcase
    end
  endtask

  initial begin
    bit traceOk;
    void'($urandom(32'h9d3a));
    clearInputs();
    rstN_i = 1'b0;
    hostAddr_i = '0;
    hostWdata_i = '0;
    hostBe_i = '0;
    fillPattern_i = '0;
    expData = '0;
    loadTrace(traceOk);
    if (!traceOk) begin
      $display("Cannot open the trace file tb/mem_trace.txt");
      $display("CHECKS FAILED");
      $finish;
    end else begin
      repeat (2) @(posedge clk_i);
      @(negedge clk_i) rstN_i = 1'b1;
      runTrace();
      repeat (Latency + 2) nextCycle();
      testId = testId + 1; // Closes the last test report
      repeat (2) nextCycle();
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

  initial begin
    wait (limit != 0);
    repeat (limit) @(posedge clk_i);
    $display("Timeout: the run did not end within %0d cycles", limit);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: tb/memSubsys_chk.sv
// Fill protocol and address range assertions, bound into the top level

`timescale 1ns/1ps

module memSubsys_chk import memPkg::*; #(
  parameter int unsigned NumWords = DefNumWords
) (
  input logic  clk_i,
  input logic  rstN_i,
  input logic  busy_i,
  input logic  done_i,
  input addr_t memAddr_i,
  input logic  hostReq_i,
  input logic  hostWe_i,
  input addr_t hostAddr_i
);

  int runLen; // Busy cycles so far in this pass

  always @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) runLen <= 0;
    else if (busy_i) runLen <= runLen + 1;
    else runLen <= 0;
  end

  // Done only in the cycle right after the last busy cycle
  doneAfterBusy: assert property (@(posedge clk_i) disable iff (!rstN_i)
    done_i |-> (!busy_i && $past(busy_i))) else $error("done not right after busy");
  donePulse: assert property (@(posedge clk_i) disable iff (!rstN_i)
    done_i |=> !done_i) else $error("done longer than one cycle");
  // Words written in order from 0, so the pass stays in range
  fillAddrOrder: assert property (@(posedge clk_i) disable iff (!rstN_i)
    busy_i |-> (int'(memAddr_i) == runLen) && (int'(memAddr_i) < NumWords))
    else $error("fill address out of order or out of range");
  busyLength: assert property (@(posedge clk_i) disable iff (!rstN_i)
    $fell(busy_i) |-> (runLen == NumWords)) else $error("busy length wrong");
  // Host stays in range and off the word the fill writes this cycle
  hostAddrLegal: assert property (@(posedge clk_i) disable iff (!rstN_i)
    hostReq_i |-> (int'(hostAddr_i) < NumWords) &&
      !(hostWe_i && busy_i && (hostAddr_i == memAddr_i)))
    else $error("host address out of range or on the word being filled");

endmodule

bind memSubsys memSubsys_chk #(.NumWords(NumWords)) i_memSubsysChk (
  .clk_i      (clk_i),
  .rstN_i     (rstN_i),
  .busy_i     (fillBusy_o),
  .done_i     (fillDone_o),
  .memAddr_i  (fillAddr),
  .hostReq_i  (hostReq_i),
  .hostWe_i   (hostWe_i),
  .hostAddr_i (hostAddr_i)
);

// File: tb/memScoreboard.sv
// Memory subsystem scoreboard
// Keeps a reference copy of the array and of the fill sequencer and
// predicts host read data and fill status, then compares against the DUT
// on the falling edge where all outputs are stable

`timescale 1ns/1ps

module memScoreboard import memPkg::*; #(
  parameter int unsigned NumWords = DefNumWords,
  parameter int unsigned Latency  = DefLatency
) (
  input  logic  clk_i,
  input  logic  rstN_i,
  input  logic  hostReq_i,
  input  logic  hostWe_i,
  input  addr_t hostAddr_i,
  input  data_t hostWdata_i,
  input  be_t   hostBe_i,
  input  data_t hostRdata_i,
  input  logic  fillStart_i,
  input  data_t fillPattern_i,
  input  logic  fillBusy_i,
  input  logic  fillDone_i,
  input  logic  expValid_i, // Trace gives an expected word for this read
  input  data_t expData_i,
  input  int    testId_i,   // Changes when a new test starts
  output int    checks_o,
  output int    errors_o
);

  data_t      model [NumWords] = '{default: '0}; // Array starts zeroed
  int         cycle = 0;
  int         dueQ  [$]; // Cycle at which the read shows up
  addr_t      addrQ [$];
  data_t      predQ [$]; // Model prediction
  logic       tvQ   [$];
  data_t      teQ   [$]; // Trace expectation
  data_t      held = '0; // Value the read port must show now
  fillState_e fState = FillIdle;
  int         fIdx = 0;
  data_t      fPat = '0;
  int         prevTest = 0;
  int         errAtStart = 0;

  initial begin
    checks_o = 0;
    errors_o = 0;
  end

  task automatic checkValue(input string what, input data_t got, input data_t exp);
    checks_o++;
    if (got !== exp) begin
      errors_o++;
      $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Model update on the rising edge, reads see old contents
  always @(posedge clk_i) begin
    if (rstN_i) begin
      cycle++;
      if (hostReq_i && !hostWe_i) begin
        dueQ.push_back(cycle + Latency - 1); // Last pipeline stage loads then
        addrQ.push_back(hostAddr_i);
        predQ.push_back(model[hostAddr_i]);
        tvQ.push_back(expValid_i);
        teQ.push_back(expData_i);
      end
      if (hostReq_i && hostWe_i) begin
        for (int b = 0; b < BeWidth; b++) begin
          if (hostBe_i[b]) model[hostAddr_i][b*ByteWidth +: ByteWidth] =
            hostWdata_i[b*ByteWidth +: ByteWidth]; // Enabled lanes only
        end
      end
      case (fState)
        FillIdle: begin
          if (fillStart_i) begin
            fPat   = fillPattern_i;
            fIdx   = 0;
            fState = FillRun;
          end
        end
        FillRun: begin
          model[fIdx] = fPat; // One word per busy cycle
          if (fIdx == NumWords - 1) fState = FillDone;
          else fIdx++;
        end
        default: fState = FillIdle; // Done lasts one cycle
      endcase
      if (testId_i != prevTest) begin
        if (prevTest != 0) begin
          $display("test %0d finished: %0d mismatches", prevTest, errors_o - errAtStart);
        end
        prevTest   = testId_i;
        errAtStart = errors_o;
      end
    end
  end

  // Compare on the falling edge, from the first edge out of reset
  always @(negedge clk_i) begin
    if (rstN_i && cycle > 0) begin
      checkValue("fill busy", data_t'(fillBusy_i), data_t'(fState == FillRun));
      checkValue("fill done", data_t'(fillDone_i), data_t'(fState == FillDone));
      if (dueQ.size() > 0 && dueQ[0] == cycle) begin
        held = predQ[0];
        if (tvQ[0]) begin
          checkValue($sformatf("model vs trace addr %0d", addrQ[0]), predQ[0], teQ[0]);
        end
        checkValue($sformatf("read addr %0d", addrQ[0]), hostRdata_i, held);
        void'(dueQ.pop_front());
        void'(addrQ.pop_front());
        void'(predQ.pop_front());
        void'(tvQ.pop_front());
        void'(teQ.pop_front());
      end else begin
        checkValue("read data hold", hostRdata_i, held); // No change between reads
      end
    end
  end

endmodule

// File: hdl/memSubsys.sv
// Memory subsystem top level
// Host reads and byte-masked writes go to SRAM port A, while the fill
// engine (sequencer plus word counter) owns port B and writes a pattern
// into every word. Word count and read latency are set here.

`timescale 1ns/1ps

module memSubsys import memPkg::*; #(
  parameter int unsigned NumWords = DefNumWords, // Up to 2**AddrWidth
  parameter int unsigned Latency  = DefLatency   // Host read latency
) (
  input  logic  clk_i,
  input  logic  rstN_i,
  // Host port
  input  logic  hostReq_i,
  input  logic  hostWe_i,
  input  addr_t hostAddr_i,
  input  data_t hostWdata_i,
  input  be_t   hostBe_i,
  output data_t hostRdata_o,
  // Fill engine control
  input  logic  fillStart_i,
  input  data_t fillPattern_i,
  output logic  fillBusy_o,
  output logic  fillDone_o
);

  logic  cntClear; // Sequencer to counter
  logic  cntStep;
  addr_t cntValue; // Counter back to sequencer
  logic  cntLast;
  logic  fillReq;  // Sequencer to port B
  addr_t fillAddr;
  data_t fillWdata;

  fillCtrl i_fillCtrl (
    .clk_i      (clk_i),
    .rstN_i     (rstN_i),
    .start_i    (fillStart_i),
    .pattern_i  (fillPattern_i),
    .count_i    (cntValue),
    .last_i     (cntLast),
    .clear_o    (cntClear),
    .step_o     (cntStep),
    .memReq_o   (fillReq),
    .memAddr_o  (fillAddr),
    .memWdata_o (fillWdata),
    .busy_o     (fillBusy_o),
    .done_o     (fillDone_o)
  );

  wordCounter #(
    .NumWords (NumWords)
  ) i_wordCounter (
    .clk_i   (clk_i),
    .rstN_i  (rstN_i),
    .clear_i (cntClear),
    .step_i  (cntStep),
    .count_o (cntValue),
    .last_o  (cntLast)
  );

  sramDualPort #(
    .NumWords (NumWords),
    .Latency  (Latency)
  ) i_sramDualPort (
    .clk_i    (clk_i),
    .rstN_i   (rstN_i),
    .reqA_i   (hostReq_i),
    .weA_i    (hostWe_i),
    .addrA_i  (hostAddr_i),
    .wdataA_i (hostWdata_i),
    .beA_i    (hostBe_i),
    .rdataA_o (hostRdata_o),
    .reqB_i   (fillReq),
    .weB_i    (1'b1), // Fill port only ever writes
    .addrB_i  (fillAddr),
    .wdataB_i (fillWdata),
    .beB_i    ('1),   // Whole words
    .rdataB_o ()      // Fill engine never reads
  );

endmodule

// File: hdl/fillCtrl.sv
// Fill engine sequencer
// A start pulse in idle captures the pattern and clears the word counter.
// The run state then writes the pattern at the counter address every
// cycle, stepping the counter, until the last word is written, and a
// single done cycle follows before going back to idle.

`timescale 1ns/1ps

module fillCtrl import memPkg::*; (
  input  logic  clk_i,
  input  logic  rstN_i,
  input  logic  start_i,    // One cycle start pulse
  input  data_t pattern_i,  // Word to write everywhere
  input  addr_t count_i,    // From the word counter
  input  logic  last_i,     // Counter on the final word
  output logic  clear_o,    // Counter clear
  output logic  step_o,     // Counter advance
  output logic  memReq_o,   // Port B write strobe
  output addr_t memAddr_o,  // Port B address
  output data_t memWdata_o, // Port B write data
  output logic  busy_o,     // High for the whole pass
  output logic  done_o      // Pulse after the pass
);

  fillState_e state;
  fillState_e stateNext;
  data_t      patternQ; // Pattern held for the pass
  logic       startAcc; // Start taken, only in idle
  logic       running;

  assign startAcc = (state == FillIdle) && start_i; // Ignored while busy or done
  assign running  = (state == FillRun);

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      state <= FillIdle;
    end else begin
      state <= stateNext;
    end
  end

  always_ff @(posedge clk_i) begin
    if (startAcc) begin
      patternQ <= pattern_i;
    end
  end

  always_comb begin
    stateNext = state;
    unique case (state)
      FillIdle: if (start_i) stateNext = FillRun;
      FillRun:  if (last_i) stateNext = FillDone; // Last word written this cycle
      FillDone: stateNext = FillIdle;             // One cycle only
      default:  stateNext = FillIdle;
    endcase
  end

  // Counter control
  assign clear_o = startAcc;
  assign step_o  = running;

  // Memory port B, one write per run cycle
  assign memReq_o   = running;
  assign memAddr_o  = count_i;
  assign memWdata_o = patternQ;

  // Status
  assign busy_o = running;
  assign done_o = (state == FillDone);

endmodule

// File: hdl/wordCounter.sv
// Word address counter for the fill engine
// Clears to zero, advances by one per step and flags the last word
// of the configured array size

`timescale 1ns/1ps

module wordCounter import memPkg::*; #(
  parameter int unsigned NumWords = DefNumWords // Configured word count
) (
  input  logic  clk_i,
  input  logic  rstN_i,
  input  logic  clear_i, // Back to word 0, wins over step
  input  logic  step_i,  // Advance one word
  output addr_t count_o, // Current word address
  output logic  last_o   // Count sits on the final word
);

  localparam addr_t LastWord = addr_t'(NumWords - 1);

  addr_t countQ;

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      countQ <= '0;
    end else if (clear_i) begin
      countQ <= '0;
    end else if (step_i) begin
      countQ <= countQ + addr_t'(1); // Wraps past the top, never read then
    end
  end

  assign count_o = countQ;
  assign last_o  = (countQ == LastWord); // Ends the fill pass

endmodule

// File: hdl/sramDualPort.sv
// Two-port synchronous SRAM model with byte-lane writes
// Both ports write on the rising edge, each lane under its own enable bit.
// Reads go through a Latency-deep register pipeline per port whose first
// stage only loads on a read, so the output holds between reads and
// during writes. Read registers reset to zero, the array starts zeroed.

`timescale 1ns/1ps

module sramDualPort import memPkg::*; #(
  parameter int unsigned NumWords = DefNumWords, // Words in the array
  parameter int unsigned Latency  = DefLatency   // Read latency, at least 1
) (
  input  logic  clk_i,
  input  logic  rstN_i,
  // Port A
  input  logic  reqA_i,   // Access strobe
  input  logic  weA_i,    // Write when set, read otherwise
  input  addr_t addrA_i,
  input  data_t wdataA_i,
  input  be_t   beA_i,    // Byte-lane enables for writes
  output data_t rdataA_o,
  // Port B
  input  logic  reqB_i,
  input  logic  weB_i,
  input  addr_t addrB_i,
  input  data_t wdataB_i,
  input  be_t   beB_i,
  output data_t rdataB_o
);

  localparam int unsigned NumPorts = 2;

  // Ports gathered into arrays so both share the same logic
  logic  req   [NumPorts];
  logic  we    [NumPorts];
  addr_t addr  [NumPorts];
  data_t wdata [NumPorts];
  be_t   be    [NumPorts];
  data_t rdata [NumPorts];

  data_t memArray [NumWords] = '{default: '0}; // Zero contents at time zero

  assign req[0]   = reqA_i;
  assign we[0]    = weA_i;
  assign addr[0]  = addrA_i;
  assign wdata[0] = wdataA_i;
  assign be[0]    = beA_i;
  assign req[1]   = reqB_i;
  assign we[1]    = weB_i;
  assign addr[1]  = addrB_i;
  assign wdata[1] = wdataB_i;
  assign be[1]    = beB_i;

  assign rdataA_o = rdata[0];
  assign rdataB_o = rdata[1];

  // Byte-lane writes, port B after port A (same-word collision is undefined)
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < NumPorts; p++) begin
      if (req[p] && we[p]) begin
        for (int b = 0; b < BeWidth; b++) begin
          if (be[p][b]) begin
            memArray[addr[p]][b*ByteWidth +: ByteWidth] <=
              wdata[p][b*ByteWidth +: ByteWidth]; // Cleared lanes keep old bytes
          end
        end
      end
    end
  end

  // Read pipelines, one per port
  for (genvar p = 0; p < NumPorts; p++) begin : gen_readPipe
    data_t stage [Latency]; // Stage 0 samples the array

    always_ff @(posedge clk_i or negedge rstN_i) begin
      if (!rstN_i) begin
        for (int s = 0; s < Latency; s++) begin
          stage[s] <= '0;
        end
      end else begin
        if (req[p] && !we[p]) begin
          stage[0] <= memArray[addr[p]]; // Old contents on same-cycle write
        end
        // Later stages shift freely, the held stage 0 keeps them steady
        for (int s = 1; s < Latency; s++) begin
          stage[s] <= stage[s-1];
        end
      end
    end

    assign rdata[p] = stage[Latency-1]; // Valid Latency cycles after request
  end

endmodule

// File: hdl/memPkg.sv
// Memory subsystem package
// Word, byte-lane and address sizes shared by the SRAM, the fill engine
// and the top level, plus the fill sequencer state encoding

package memPkg;

  // Word geometry
  localparam int unsigned DataWidth = 32; // Bits per data word
  localparam int unsigned ByteWidth = 8;  // Bits per byte lane
  localparam int unsigned BeWidth   = DataWidth / ByteWidth; // Lanes per word
  localparam int unsigned AddrWidth = 6;  // Covers the default word count

  // Defaults for the top level parameters
  localparam int unsigned DefNumWords = 64; // At most 2**AddrWidth
  localparam int unsigned DefLatency  = 1;  // Read latency in cycles

  // Vectors with a meaning
  typedef logic [AddrWidth-1:0] addr_t; // Word address
  typedef logic [DataWidth-1:0] data_t; // Data word
  typedef logic [BeWidth-1:0]   be_t;   // Byte-lane write mask

  // Fill engine sequencer
  typedef enum logic [1:0] {
    FillIdle = 2'd0, // Waiting for a start pulse
    FillRun  = 2'd1, // One word written per cycle
    FillDone = 2'd2  // Single cycle done pulse
  } fillState_e;

endpackage
